//--- sim.f
scc_reg_pkg.sv
scc_line_pkg.sv
scc_bus_decode.sv
scc_channel.sv
scc_irq_ctrl.sv
scc_read_mux.sv
scc_tx_serial.sv
scc_top.sv
tb_scc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_scc -f sim.f -o tb_scc_sim \
	&& out="$(./obj_dir/tb_scc_sim)"; echo "$out"; \
	echo "$out" | grep -q "TEST RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_scc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_scc;

	localparam int OP_IDLE = 0;	// cs low
	localparam int OP_WR = 1;
	localparam int OP_RD = 2;
	localparam int OP_FRAME = 3;	// data write then frame sampling
	localparam int OP_HOLD = 4;	// data write with cts low, then release
	localparam int CHK_NONE = 0;
	localparam int CHK_RDATA = 1;
	localparam int CHK_IRQ = 2;
	localparam int CHK_WR14 = 3;	// wr14 has no read path so it is probed inside
	localparam logic [1:0] CTL_A = 2'b01;
	localparam logic [1:0] CTL_B = 2'b00;
	localparam logic [1:0] DATA_A = 2'b11;
	localparam int HOLD_CYCLES = 40;
	localparam int FRAME_COUNT = 2;
	localparam int WATCHDOG_MARGIN = 200;
	localparam int BIT_CLKS = scc_line_pkg::TX_CLKS_PER_BIT;

	logic clk, reset_hw, cs, we, cts, dcd_a, dcd_b;
	logic [1:0] rs;
	logic [7:0] wdata;
	wire [7:0] rdata;
	wire irq_n, txd;

	// step table as one queue per column
	string step_name[$];
	int step_op[$];
	int step_chk[$];
	logic [1:0] step_rs[$];
	logic [7:0] step_data[$];
	logic [7:0] step_exp[$];
	logic step_dcd_a[$];
	logic step_dcd_b[$];
	logic step_cts[$];
	logic line_dcd_a, line_dcd_b, line_cts;	// line levels for new steps
	int check_count = 0;
	int watchdog_cycles = 0;

	scc_top UUT (.clk, .reset_hw, .i_cs(cs), .i_we(we), .i_rs(rs), .i_wdata(wdata),
		.o_rdata(rdata), .o_irq_n(irq_n), .o_txd(txd), .i_cts(cts), .i_dcd_a(dcd_a),
		.i_dcd_b(dcd_b));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_rdata(input string name, input logic [7:0] exp, input logic [7:0] act);
		check_count++;
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "byte compare failed");
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "bit compare failed");
		end
	endtask

	task automatic set_lines(input logic l_dcd_a, input logic l_dcd_b, input logic l_cts);
		line_dcd_a = l_dcd_a;
		line_dcd_b = l_dcd_b;
		line_cts = l_cts;
	endtask

	task automatic push_step(input string name, input int op, input logic [1:0] s_rs,
		input logic [7:0] data, input int chk, input logic [7:0] exp);
		step_name.push_back(name);
		step_op.push_back(op);
		step_rs.push_back(s_rs);
		step_data.push_back(data);
		step_chk.push_back(chk);
		step_exp.push_back(exp);
		step_dcd_a.push_back(line_dcd_a);
		step_dcd_b.push_back(line_dcd_b);
		step_cts.push_back(line_cts);
	endtask

	// wr0 pointer byte with point-high for 8..15
	function automatic logic [7:0] ptr_code(input scc_reg_pkg::reg_index_t idx);
		ptr_code = {2'b00, idx[3] ? scc_reg_pkg::CMD_POINT_HIGH : 3'b000, idx[2:0]};
	endfunction

	task automatic reg_write_pair(input string name, input logic [1:0] s_rs,
		input scc_reg_pkg::reg_index_t idx, input logic [7:0] value);
		push_step(name, OP_WR, s_rs, ptr_code(idx), CHK_NONE, 8'h00);
		push_step(name, OP_WR, s_rs, value, CHK_NONE, 8'h00);
	endtask

	task automatic reg_read_pair(input string name, input logic [1:0] s_rs,
		input scc_reg_pkg::reg_index_t idx, input logic [7:0] exp);
		push_step(name, OP_WR, s_rs, ptr_code(idx), CHK_NONE, 8'h00);
		push_step(name, OP_RD, s_rs, 8'h00, CHK_RDATA, exp);
	endtask

	// caller has just passed the edge where the start bit begins
	task automatic sample_frame(input string name, input logic [7:0] data);
		logic [9:0] frame;
		int k;
		frame = {scc_line_pkg::STOP_BIT, data, scc_line_pkg::START_BIT};	// sent lsb first
		for (k = 0; k < scc_line_pkg::FRAME_BITS; k++) begin
			repeat ((k == 0) ? BIT_CLKS / 2 : BIT_CLKS) @(posedge clk);
			@(negedge clk);	// mid-bit
			check_bit(name, frame[k], txd);
			check_bit(name, 1'b0, rdata[2]);	// tx empty low while busy
		end
		repeat (BIT_CLKS / 2) @(posedge clk);
		@(negedge clk);
		check_bit(name, 1'b1, rdata[2]);
		check_bit(name, 1'b1, txd);
	endtask

	initial begin
		reset_hw = 1'b1;
		cs = 1'b0;
		we = 1'b0;
		rs = CTL_A;
		wdata = 8'h00;
		cts = 1'b1;
		dcd_a = 1'b0;
		dcd_b = 1'b0;

		// pointer, point-high and aliased readback
		set_lines(1'b0, 1'b0, 1'b1);
		reg_write_pair("wr12 a", CTL_A, scc_reg_pkg::IDX_WR12, 8'h5a);
		reg_write_pair("wr13 a", CTL_A, scc_reg_pkg::IDX_WR13, 8'h3c);
		reg_write_pair("wr15 a", CTL_A, scc_reg_pkg::IDX_WR15, 8'h77);	// bit 3 clear
		reg_write_pair("wr12 b", CTL_B, scc_reg_pkg::IDX_WR12, 8'ha5);
		reg_write_pair("wr13 b", CTL_B, scc_reg_pkg::IDX_WR13, 8'hc3);
		reg_write_pair("wr15 b", CTL_B, scc_reg_pkg::IDX_WR15, 8'h35);
		reg_read_pair("rr12 a", CTL_A, 4'd12, 8'h5a);
		reg_read_pair("rr9 a alias", CTL_A, 4'd9, 8'h3c);
		reg_read_pair("rr13 a", CTL_A, 4'd13, 8'h3c);
		reg_read_pair("rr11 a masked", CTL_A, 4'd11, 8'h72);	// 77 without bits 2 and 0
		reg_read_pair("rr12 b", CTL_B, 4'd12, 8'ha5);
		reg_read_pair("rr9 b alias", CTL_B, 4'd9, 8'hc3);
		reg_read_pair("rr11 b masked", CTL_B, 4'd11, 8'h30);	// 35 without bits 2 and 0
		reg_read_pair("rr5 alias of rr1", CTL_A, 4'd5, 8'h07);
		push_step("pointer back to rr0 a", OP_RD, CTL_A, 8'h00, CHK_RDATA, 8'h44);
		push_step("pointer back to rr0 b", OP_RD, CTL_B, 8'h00, CHK_RDATA, 8'h44);

		// channel a reset then full reset
		reg_write_pair("wr14 a", CTL_A, scc_reg_pkg::IDX_WR14, 8'hff);
		reg_write_pair("wr14 b", CTL_B, scc_reg_pkg::IDX_WR14, 8'hff);
		reg_write_pair("chan a reset", CTL_A, scc_reg_pkg::IDX_WR9, {2'b10, 6'd0});
		push_step("wr14 a after chan reset", OP_IDLE, CTL_A, 8'h00, CHK_WR14,
			{2'b11, 4'b1000, 2'b11});
		push_step("wr14 b after chan a reset", OP_IDLE, CTL_B, 8'h00, CHK_WR14, 8'hff);
		reg_read_pair("wr12 a after chan reset", CTL_A, 4'd12, 8'h5a);
		reg_write_pair("full reset", CTL_B, scc_reg_pkg::IDX_WR9, {2'b11, 6'd0});
		push_step("wr14 a after full reset", OP_IDLE, CTL_A, 8'h00, CHK_WR14, {2'b11, 6'b110000});
		push_step("wr14 b after full reset", OP_IDLE, CTL_B, 8'h00, CHK_WR14, {2'b11, 6'b110000});
		reg_read_pair("wr15 a after full reset", CTL_A, 4'd15, 8'hf8);
		reg_read_pair("wr15 b after full reset", CTL_B, 4'd15, 8'hf8);
		reg_read_pair("wr12 a after full reset", CTL_A, 4'd12, 8'h5a);
		reg_read_pair("wr12 b after full reset", CTL_B, 4'd12, 8'ha5);

		// dcd ext/status interrupt on a
		reg_write_pair("wr1 ext ie", CTL_A, scc_reg_pkg::IDX_WR1, 8'h01);
		reg_write_pair("wr15 dcd ie", CTL_A, scc_reg_pkg::IDX_WR15, 8'h08);
		reg_write_pair("wr2 vector", CTL_A, scc_reg_pkg::IDX_WR2, 8'h81);
		reg_write_pair("wr9 mie", CTL_A, scc_reg_pkg::IDX_WR9, 8'h08);
		push_step("irq idle", OP_IDLE, CTL_A, 8'h00, CHK_IRQ, 8'h01);
		set_lines(1'b1, 1'b0, 1'b1);
		push_step("dcd rises", OP_IDLE, CTL_A, 8'h00, CHK_IRQ, 8'h01);	// latches next edge
		push_step("irq asserted", OP_IDLE, CTL_A, 8'h00, CHK_IRQ, 8'h00);
		reg_read_pair("rr3 a pending", CTL_A, 4'd3, 8'h08);
		push_step("rr0 a dcd set", OP_RD, CTL_A, 8'h00, CHK_RDATA, 8'h4c);
		set_lines(1'b0, 1'b0, 1'b1);
		push_step("rr0 a dcd latched", OP_RD, CTL_A, 8'h00, CHK_RDATA, 8'h4c);
		set_lines(1'b1, 1'b0, 1'b1);	// back to latched level before reopening
		reg_read_pair("rr2 a plain wr2", CTL_A, 4'd2, 8'h81);
		reg_read_pair("rr2 b status low", CTL_B, 4'd2, 8'h8b);	// 101 in 3..1
		reg_write_pair("wr9 status high", CTL_A, scc_reg_pkg::IDX_WR9, 8'h18);
		reg_read_pair("rr2 b status high", CTL_B, 4'd2, 8'hd1);	// 101 reversed in 6..4
		push_step("ext reset cmd", OP_WR, CTL_A, {2'b00, 3'b010, 3'b000}, CHK_IRQ, 8'h00);
		push_step("irq released", OP_IDLE, CTL_A, 8'h00, CHK_IRQ, 8'h01);
		reg_read_pair("rr2 b no source", CTL_B, 4'd2, 8'he1);	// 011 reversed
		reg_read_pair("rr3 a cleared", CTL_A, 4'd3, 8'h00);

		// transmit then cts hold
		push_step("frame a5", OP_FRAME, DATA_A, 8'ha5, CHK_NONE, 8'h00);
		set_lines(1'b1, 1'b0, 1'b0);
		push_step("frame 96 cts hold", OP_HOLD, DATA_A, 8'h96, CHK_NONE, 8'h00);

		watchdog_cycles = 2 + step_name.size() + HOLD_CYCLES + WATCHDOG_MARGIN +
			FRAME_COUNT * (scc_line_pkg::FRAME_BITS * BIT_CLKS + BIT_CLKS);

		repeat (2) @(posedge clk);
		reset_hw <= 1'b0;

		for (int i = 0; i < step_name.size(); i++) begin
			@(posedge clk);
			cs <= (step_op[i] != OP_IDLE);
			we <= (step_op[i] == OP_WR) || (step_op[i] == OP_FRAME) || (step_op[i] == OP_HOLD);
			rs <= step_rs[i];
			wdata <= step_data[i];
			dcd_a <= step_dcd_a[i];
			dcd_b <= step_dcd_b[i];
			cts <= step_cts[i];
			@(negedge clk);
			case (step_chk[i])
				CHK_RDATA: check_rdata(step_name[i], step_exp[i], rdata);
				CHK_IRQ: check_bit(step_name[i], step_exp[i][0], irq_n);
				CHK_WR14: check_rdata(step_name[i], step_exp[i],
					step_rs[i][0] ? UUT.chan_a.wr14 : UUT.chan_b.wr14);
				default: ;
			endcase
			if (step_op[i] == OP_FRAME || step_op[i] == OP_HOLD) begin
				@(posedge clk);	// load edge
				we <= 1'b0;
				rs <= CTL_A;	// keep reading rr0 a
				if (step_op[i] == OP_HOLD) begin
					repeat (HOLD_CYCLES) begin
						@(negedge clk);
						check_bit(step_name[i], 1'b1, txd);
						check_bit(step_name[i], 1'b0, rdata[2]);
						@(posedge clk);
					end
					cts <= 1'b1;
					@(posedge clk);	// start bit goes out here
				end
				sample_frame(step_name[i], step_data[i]);
			end
		end

		if (check_count > 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("no checks were run");
			$display("TEST RESULT: FAIL");
			$fatal(1, "empty run");
		end
	end

	// ends a stuck run
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the test sequence did not finish in time");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- scc_top.sv
`timescale 1ns/10ps
`default_nettype none

module scc_top (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs,	// [1] data side, [0] channel a
	input wire [7:0] i_wdata,
	output wire [7:0] o_rdata,
	output wire o_irq_n,
	output wire o_txd,
	input wire i_cts,
	input wire i_dcd_a,
	input wire i_dcd_b
);

	wire scc_reg_pkg::reg_index_t index;
	wire wr_a, wr_b, rst_full, rst_a, rst_b;
	wire ext_reset_a, ext_reset_b, load_tx, tx_busy;
	wire [7:0] wr12_a, wr13_a, wr15_a, wr12_b, wr13_b, wr15_b;
	wire dcd_status_a, dcd_status_b, ext_pending_a, ext_pending_b;
	wire [7:0] wr2, rr3;
	wire scc_reg_pkg::rr2_word_t rr2;

	scc_bus_decode u_decode (.clk, .reset_hw, .i_cs, .i_we, .i_rs, .i_wdata, .o_index(index),
		.o_wr_a(wr_a), .o_wr_b(wr_b), .o_rst_full(rst_full), .o_rst_a(rst_a), .o_rst_b(rst_b),
		.o_ext_reset_a(ext_reset_a), .o_ext_reset_b(ext_reset_b), .o_load_tx(load_tx));

	scc_channel chan_a (.clk, .reset_hw, .i_wr(wr_a), .i_index(index), .i_wdata,
		.i_rst_full(rst_full), .i_rst_chan(rst_a), .i_ext_reset(ext_reset_a), .i_dcd(i_dcd_a),
		.o_wr12(wr12_a), .o_wr13(wr13_a), .o_wr15(wr15_a), .o_dcd_status(dcd_status_a),
		.o_ext_pending(ext_pending_a));

	scc_channel chan_b (.clk, .reset_hw, .i_wr(wr_b), .i_index(index), .i_wdata,
		.i_rst_full(rst_full), .i_rst_chan(rst_b), .i_ext_reset(ext_reset_b), .i_dcd(i_dcd_b),
		.o_wr12(wr12_b), .o_wr13(wr13_b), .o_wr15(wr15_b), .o_dcd_status(dcd_status_b),
		.o_ext_pending(ext_pending_b));

	scc_irq_ctrl u_irq (.clk, .reset_hw, .i_wr_any(wr_a | wr_b), .i_index(index), .i_wdata,
		.i_ext_pending_a(ext_pending_a), .i_ext_pending_b(ext_pending_b), .o_wr2(wr2),
		.o_rr2(rr2), .o_rr3(rr3), .o_irq_n);

	scc_read_mux u_rmux (.i_rs, .i_index(index), .i_tx_busy(tx_busy),
		.i_dcd_status_a(dcd_status_a), .i_dcd_status_b(dcd_status_b),
		.i_wr12_a(wr12_a), .i_wr12_b(wr12_b), .i_wr13_a(wr13_a), .i_wr13_b(wr13_b),
		.i_wr15_a(wr15_a), .i_wr15_b(wr15_b), .i_wr2(wr2), .i_rr2(rr2), .i_rr3(rr3), .o_rdata);

	// channel a only, full reset aborts too
	scc_tx_serial #(.CLKS_PER_BIT(scc_line_pkg::TX_CLKS_PER_BIT)) u_tx (.clk, .reset_hw,
		.i_rst_chan(rst_a | rst_full), .i_load(load_tx), .i_data(i_wdata), .i_cts,
		.o_txd, .o_busy(tx_busy));

endmodule

`default_nettype wire

//--- scc_tx_serial.sv
`timescale 1ns/10ps
`default_nettype none

module scc_tx_serial #(
	parameter int CLKS_PER_BIT = scc_line_pkg::TX_CLKS_PER_BIT
) (
	input wire clk,
	input wire reset_hw,
	input wire i_rst_chan,	// abort frame
	input wire i_load,
	input wire [7:0] i_data,
	input wire i_cts,
	output logic o_txd,
	output logic o_busy
);

	logic sending;	// busy without sending means waiting for cts
	logic [$clog2(CLKS_PER_BIT + 1)-1:0] clk_cnt;
	logic [$clog2(scc_line_pkg::FRAME_BITS)-1:0] bit_cnt;
	logic [scc_line_pkg::DATA_BITS:0] shift_q;	// stop bit on top, no reset

	always_ff @(posedge clk) begin
		if (i_load && !o_busy)
			shift_q <= {scc_line_pkg::STOP_BIT, i_data};
		else if (sending && clk_cnt == CLKS_PER_BIT - 1)
			shift_q <= {scc_line_pkg::STOP_BIT, shift_q[scc_line_pkg::DATA_BITS:1]};
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw || i_rst_chan) begin
			o_txd <= scc_line_pkg::STOP_BIT;	// idle high
			o_busy <= 1'b0;
			sending <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!o_busy) begin
			if (i_load) begin
				o_busy <= 1'b1;
				sending <= i_cts;
				o_txd <= i_cts ? scc_line_pkg::START_BIT : scc_line_pkg::STOP_BIT;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (!sending) begin
			if (i_cts) begin	// held byte goes out now
				sending <= 1'b1;
				o_txd <= scc_line_pkg::START_BIT;
			end
		end else if (clk_cnt == CLKS_PER_BIT - 1) begin
			clk_cnt <= '0;
			if (bit_cnt == scc_line_pkg::FRAME_BITS - 1) begin
				o_busy <= 1'b0;	// stop bit done
				sending <= 1'b0;
				o_txd <= scc_line_pkg::STOP_BIT;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				o_txd <= shift_q[0];	// lsb first
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- scc_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

module scc_read_mux (
	input wire [1:0] i_rs,
	input wire scc_reg_pkg::reg_index_t i_index,
	input wire i_tx_busy,	// channel a only
	input wire i_dcd_status_a,
	input wire i_dcd_status_b,
	input wire [7:0] i_wr12_a,
	input wire [7:0] i_wr12_b,
	input wire [7:0] i_wr13_a,
	input wire [7:0] i_wr13_b,
	input wire [7:0] i_wr15_a,
	input wire [7:0] i_wr15_b,
	input wire [7:0] i_wr2,
	input wire scc_reg_pkg::rr2_word_t i_rr2,
	input wire [7:0] i_rr3,
	output logic [7:0] o_rdata
);

	logic side_a;
	logic [7:0] rr0;

	assign side_a = i_rs[0];
	// tx underrun/eom always set, b never transmits
	assign rr0 = side_a ? {2'b01, 2'b00, i_dcd_status_a, ~i_tx_busy, 2'b00} :
		{2'b01, 2'b00, i_dcd_status_b, 1'b1, 2'b00};

	always_comb begin
		o_rdata = 8'h00;	// data side, rr8, rr10/14
		if (!i_rs[1]) begin
			case (i_index)
				4'd0, 4'd4: o_rdata = rr0;
				4'd1, 4'd5: o_rdata = scc_reg_pkg::RR1_FIXED;
				4'd2, 4'd6: o_rdata = side_a ? i_wr2 : i_rr2;	// vector with status on b
				4'd3, 4'd7: o_rdata = side_a ? i_rr3 : 8'h00;
				4'd9, 4'd13: o_rdata = side_a ? i_wr13_a : i_wr13_b;
				4'd12: o_rdata = side_a ? i_wr12_a : i_wr12_b;
				4'd11, 4'd15: o_rdata = (side_a ? i_wr15_a : i_wr15_b) & scc_reg_pkg::RR15_MASK;
				default: o_rdata = 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- scc_irq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module scc_irq_ctrl (
	input wire clk,
	input wire reset_hw,
	input wire i_wr_any,	// control write from either side
	input wire scc_reg_pkg::reg_index_t i_index,
	input wire [7:0] i_wdata,
	input wire i_ext_pending_a,
	input wire i_ext_pending_b,
	output logic [7:0] o_wr2,
	output scc_reg_pkg::rr2_word_t o_rr2,
	output logic [7:0] o_rr3,
	output logic o_irq_n
);

	logic [5:0] wr9;	// reset field is not stored
	logic [2:0] vec_stat;
	scc_reg_pkg::rr2_word_t vec_word;

	// shared registers, survive soft resets
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr2 <= '0;
			wr9 <= '0;
		end else if (i_wr_any) begin
			if (i_index == scc_reg_pkg::IDX_WR2)
				o_wr2 <= i_wdata;
			if (i_index == scc_reg_pkg::IDX_WR9)
				wr9 <= i_wdata[5:0];
		end
	end

	// a over b, only ext sources remain
	assign vec_stat = i_ext_pending_a ? scc_reg_pkg::VEC_EXT_A :
		i_ext_pending_b ? scc_reg_pkg::VEC_EXT_B : scc_reg_pkg::VEC_NONE;

	always_comb begin
		vec_word = o_wr2;
		if (wr9[4])	// status high
			vec_word.status_high.status = {vec_stat[0], vec_stat[1], vec_stat[2]};
		else
			vec_word.status_low.status = vec_stat;
		o_rr2 = vec_word;
	end

	assign o_rr3 = {4'b0000, i_ext_pending_a, 2'b00, i_ext_pending_b};
	assign o_irq_n = ~(wr9[3] & (i_ext_pending_a | i_ext_pending_b));	// mie gate

endmodule

`default_nettype wire

//--- scc_channel.sv
`timescale 1ns/10ps
`default_nettype none

module scc_channel (
	input wire clk,
	input wire reset_hw,
	input wire i_wr,	// control write strobe for this side
	input wire scc_reg_pkg::reg_index_t i_index,
	input wire [7:0] i_wdata,
	input wire i_rst_full,
	input wire i_rst_chan,
	input wire i_ext_reset,
	input wire i_dcd,	// raw line level
	output logic [7:0] o_wr12,
	output logic [7:0] o_wr13,
	output logic [7:0] o_wr15,
	output logic o_dcd_status,
	output logic o_ext_pending
);

	logic [7:0] wr1;
	logic [7:0] wr14;
	logic chan_reset;	// full reset implies channel reset
	logic latch_open;
	logic dcd_latch;
	logic do_latch;

	assign chan_reset = i_rst_chan | i_rst_full;
	// latch closes on first dcd change while enabled in wr15
	assign do_latch = latch_open & o_wr15[3] & (i_dcd != dcd_latch);

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr1 <= '0;
		else if (chan_reset)
			wr1 <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00};	// 5 and 2 survive
		else if (i_wr && i_index == scc_reg_pkg::IDX_WR1)
			wr1 <= i_wdata;
	end

	// baud time constant cleared by hw reset only
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr12 <= '0;
			o_wr13 <= '0;
		end else if (i_wr) begin
			if (i_index == scc_reg_pkg::IDX_WR12)
				o_wr12 <= i_wdata;
			if (i_index == scc_reg_pkg::IDX_WR13)
				o_wr13 <= i_wdata;
		end
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr14 <= {2'b00, scc_reg_pkg::WR14_FULL_LOW};	// hw reset is a full reset
		else if (i_rst_full)
			wr14 <= {wr14[7:6], scc_reg_pkg::WR14_FULL_LOW};
		else if (i_rst_chan)
			wr14 <= {wr14[7:6], scc_reg_pkg::WR14_CHAN_MID, wr14[1:0]};
		else if (i_wr && i_index == scc_reg_pkg::IDX_WR14)
			wr14 <= i_wdata;
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			o_wr15 <= scc_reg_pkg::WR15_RESET;
		else if (i_rst_full)
			o_wr15 <= scc_reg_pkg::WR15_RESET;	// channel reset leaves it
		else if (i_wr && i_index == scc_reg_pkg::IDX_WR15)
			o_wr15 <= i_wdata;
	end

	// ext/status latch and pending bit
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw || i_rst_full) begin
			latch_open <= 1'b1;
			dcd_latch <= 1'b0;
			o_ext_pending <= 1'b0;
		end else if (i_ext_reset) begin
			latch_open <= 1'b1;	// reopen for the next dcd change
			o_ext_pending <= 1'b0;
		end else if (do_latch) begin
			latch_open <= 1'b0;
			dcd_latch <= i_dcd;
			if (wr1[0])
				o_ext_pending <= 1'b1;	// ext int enable
		end
	end

	assign o_dcd_status = o_wr15[3] ? dcd_latch : i_dcd;

	a_pend_needs_ie: assert property (@(posedge clk) disable iff (reset_hw)
		$rose(o_ext_pending) |-> $past(wr1[0]));

endmodule

`default_nettype wire

//--- scc_bus_decode.sv
`timescale 1ns/10ps
`default_nettype none

module scc_bus_decode (
	input wire clk,
	input wire reset_hw,
	input wire i_cs,
	input wire i_we,
	input wire [1:0] i_rs,	// [1] data side, [0] channel a
	input wire [7:0] i_wdata,
	output scc_reg_pkg::reg_index_t o_index,
	output logic o_wr_a,
	output logic o_wr_b,
	output logic o_rst_full,
	output logic o_rst_a,
	output logic o_rst_b,
	output logic o_ext_reset_a,
	output logic o_ext_reset_b,
	output logic o_load_tx
);

	logic ctl_access;	// any control-side cycle
	logic data_wr_a;	// data port write, same as wr8
	logic wr9_write;
	logic ext_cmd;
	logic rst_full_cmd;

	assign ctl_access = i_cs & ~i_rs[1];
	assign o_wr_a = ctl_access & i_we & i_rs[0];
	assign o_wr_b = ctl_access & i_we & ~i_rs[0];
	assign data_wr_a = i_cs & i_we & i_rs[1] & i_rs[0];

	// pointer lives for exactly one access after a wr0 write
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_index <= scc_reg_pkg::IDX_WR0;
		end else if (ctl_access) begin
			if (i_we && o_index == scc_reg_pkg::IDX_WR0)
				o_index <= {i_wdata[5:3] == scc_reg_pkg::CMD_POINT_HIGH, i_wdata[2:0]};
			else
				o_index <= scc_reg_pkg::IDX_WR0;	// back to wr0
		end
	end

	assign wr9_write = (o_wr_a | o_wr_b) & (o_index == scc_reg_pkg::IDX_WR9);

	// wr9 is shared, either side can issue resets
	always_comb begin
		rst_full_cmd = 1'b0;
		o_rst_a = 1'b0;
		o_rst_b = 1'b0;
		if (wr9_write) begin
			case (i_wdata[7:6])
				scc_reg_pkg::RST_FULL: rst_full_cmd = 1'b1;
				scc_reg_pkg::RST_CHAN_A: o_rst_a = 1'b1;
				scc_reg_pkg::RST_CHAN_B: o_rst_b = 1'b1;
				scc_reg_pkg::RST_NONE: ;	// only low bits change
			endcase
		end
	end
	assign o_rst_full = rst_full_cmd | reset_hw;	// hw reset behaves as full reset

	assign ext_cmd = (o_index == scc_reg_pkg::IDX_WR0) &
		(i_wdata[5:3] == scc_reg_pkg::CMD_RESET_EXT);
	assign o_ext_reset_a = o_wr_a & ext_cmd;
	assign o_ext_reset_b = o_wr_b & ext_cmd;

	// tx load through pointer 8 or the data port
	assign o_load_tx = (o_wr_a & (o_index == scc_reg_pkg::IDX_WR8)) | data_wr_a;

	// channel and full resets never overlap downstream
	a_one_reset: assert property (@(posedge clk) disable iff (reset_hw)
		$onehot0({o_rst_full, o_rst_a, o_rst_b}));

endmodule

`default_nettype wire

//--- scc_line_pkg.sv
`default_nettype none

package scc_line_pkg;

	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 2;	// start + data + stop
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;	// also the idle level

	localparam int TX_CLKS_PER_BIT = 16;	// short period for simulation

endpackage

`default_nettype wire

//--- scc_reg_pkg.sv
`default_nettype none

package scc_reg_pkg;

	typedef logic [3:0] reg_index_t;	// register pointer value

	// write register numbers
	localparam reg_index_t IDX_WR0 = 4'd0;
	localparam reg_index_t IDX_WR1 = 4'd1;
	localparam reg_index_t IDX_WR2 = 4'd2;
	localparam reg_index_t IDX_WR8 = 4'd8;
	localparam reg_index_t IDX_WR9 = 4'd9;
	localparam reg_index_t IDX_WR12 = 4'd12;
	localparam reg_index_t IDX_WR13 = 4'd13;
	localparam reg_index_t IDX_WR14 = 4'd14;
	localparam reg_index_t IDX_WR15 = 4'd15;

	// wr0 command field, bits 5..3
	localparam logic [2:0] CMD_POINT_HIGH = 3'b001;	// pointer += 8
	localparam logic [2:0] CMD_RESET_EXT = 3'b010;	// reopen ext/status latch

	// wr9 reset field, bits 7..6
	localparam logic [1:0] RST_NONE = 2'b00;
	localparam logic [1:0] RST_CHAN_B = 2'b01;
	localparam logic [1:0] RST_CHAN_A = 2'b10;
	localparam logic [1:0] RST_FULL = 2'b11;

	localparam logic [7:0] WR15_RESET = 8'hf8;
	localparam logic [5:0] WR14_FULL_LOW = 6'b110000;	// below the kept bits 7..6
	localparam logic [3:0] WR14_CHAN_MID = 4'b1000;	// into bits 5..2
	localparam logic [7:0] RR1_FIXED = 8'h07;	// all sent, residue 011
	localparam logic [7:0] RR15_MASK = 8'hfa;	// bits 2 and 0 read as zero

	// rr2 status codes, no rx or tx sources left
	localparam logic [2:0] VEC_EXT_A = 3'b101;
	localparam logic [2:0] VEC_EXT_B = 3'b001;
	localparam logic [2:0] VEC_NONE = 3'b011;

	// vector word, status either in 3..1 or reversed in 6..4
	typedef union packed {
		struct packed {logic [3:0] upper; logic [2:0] status; logic lsb;} status_low;
		struct packed {logic msb; logic [2:0] status; logic [3:0] lower;} status_high;
	} rr2_word_t;

endpackage

`default_nettype wire
